//--- rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen = 32;

    // rv32i major opcodes, ins[6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'h37,
        OPC_AUIPC  = 7'h17,
        OPC_JAL    = 7'h6f,
        OPC_JALR   = 7'h67,
        OPC_BRANCH = 7'h63,
        OPC_LOAD   = 7'h03,
        OPC_STORE  = 7'h23,
        OPC_OP_IMM = 7'h13,
        OPC_OP     = 7'h33,
        OPC_FENCE  = 7'h0f,
        OPC_SYSTEM = 7'h73
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_AND  = 4'b0000,
        ALU_OR   = 4'b0001,
        ALU_ADD  = 4'b0010,
        ALU_EQU  = 4'b0011,
        ALU_SGE  = 4'b0100,
        ALU_SGEU = 4'b0101,
        ALU_SUB  = 4'b0110,
        ALU_XOR  = 4'b0111,
        ALU_SLL  = 4'b1000,
        ALU_SLT  = 4'b1001,
        ALU_SLTU = 4'b1010,
        ALU_SRL  = 4'b1011,
        ALU_SRA  = 4'b1100,
        ALU_IN1  = 4'b1101,  // pass operand 1
        ALU_IN2  = 4'b1110   // pass operand 2
    } alu_op_e;

    // load/store access width
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      src1_pc;     // operand 1 from pc instead of rs1
        logic      src1_pc4;    // with src1_pc, use pc+4
        logic      src2_imm;    // operand 2 from imm instead of rs2
        logic      mem_read;
        logic      mem_write;
        logic      mem_to_reg;  // load data to rd
        mem_size_e mem_size;
        logic      mem_signed;  // sign extend loads
        logic      reg_write;
        logic      branch;      // taken when alu zero
        logic      jump;        // jal
        logic      jalr;
        logic      halt;        // ecall, ebreak, unknown
    } ctrl_t;

endpackage

//--- rv_bus_pkg.sv
package rv_bus_pkg;

    localparam int mem_words = 1024;
    localparam int mem_aw    = $clog2(mem_words);  // word index bits
    localparam int addr_w    = 32;

    // master to slave
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [addr_w-1:0] paddr;
        logic [31:0]       pwdata;
        logic [3:0]        pstrb;
    } apb_req_t;

    // slave to master
    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
    } apb_rsp_t;

endpackage

//--- rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  logic [rv_isa_pkg::xlen-1:0] ins,
    output rv_isa_pkg::ctrl_t           ctrl,
    output logic [rv_isa_pkg::xlen-1:0] imm
);
    import rv_isa_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       f7_5;

    assign opcode = opcode_e'(ins[6:0]);
    assign funct3 = ins[14:12];
    assign f7_5   = ins[30];  // sub and sra select

    always_comb begin
        ctrl          = '0;
        ctrl.alu_op   = ALU_AND;
        ctrl.mem_size = SIZE_WORD;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.src2_imm  = (opcode == OPC_OP_IMM);
                case (funct3)
                    3'h0: ctrl.alu_op = (f7_5 && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
                    3'h1: ctrl.alu_op = ALU_SLL;
                    3'h2: ctrl.alu_op = ALU_SLT;
                    3'h3: ctrl.alu_op = ALU_SLTU;
                    3'h4: ctrl.alu_op = ALU_XOR;
                    3'h5: ctrl.alu_op = f7_5 ? ALU_SRA : ALU_SRL;
                    3'h6: ctrl.alu_op = ALU_OR;
                    default: ctrl.alu_op = ALU_AND;
                endcase
            end
            OPC_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.src2_imm  = 1'b1;
                ctrl.alu_op    = ALU_IN2;
            end
            OPC_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.src1_pc   = 1'b1;
                ctrl.src2_imm  = 1'b1;
                ctrl.alu_op    = ALU_ADD;
            end
            OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.src1_pc   = 1'b1;
                ctrl.src1_pc4  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.alu_op    = ALU_IN1;  // link value is pc+4
            end
            OPC_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.src2_imm  = 1'b1;
                ctrl.jalr      = 1'b1;
                ctrl.alu_op    = ALU_ADD;  // target rs1+imm
            end
            OPC_BRANCH: begin
                ctrl.branch = 1'b1;
                case (funct3)  // op gives zero when taken
                    3'h0: ctrl.alu_op = ALU_XOR;   // beq
                    3'h1: ctrl.alu_op = ALU_EQU;   // bne
                    3'h4: ctrl.alu_op = ALU_SGE;   // blt
                    3'h5: ctrl.alu_op = ALU_SLT;   // bge
                    3'h6: ctrl.alu_op = ALU_SGEU;  // bltu
                    default: ctrl.alu_op = ALU_SLTU;  // bgeu
                endcase
            end
            OPC_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.src2_imm   = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_op     = ALU_ADD;
                case (funct3)
                    3'h0: begin
                        ctrl.mem_size   = SIZE_BYTE;
                        ctrl.mem_signed = 1'b1;
                    end
                    3'h1: begin
                        ctrl.mem_size   = SIZE_HALF;
                        ctrl.mem_signed = 1'b1;
                    end
                    3'h2: ctrl.mem_size = SIZE_WORD;
                    3'h4: ctrl.mem_size = SIZE_BYTE;
                    default: ctrl.mem_size = SIZE_HALF;  // lhu
                endcase
            end
            OPC_STORE: begin
                ctrl.src2_imm  = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.alu_op    = ALU_ADD;
                case (funct3)
                    3'h0: ctrl.mem_size = SIZE_BYTE;
                    3'h1: ctrl.mem_size = SIZE_HALF;
                    default: ctrl.mem_size = SIZE_WORD;
                endcase
            end
            OPC_FENCE: ;  // nop
            OPC_SYSTEM: ctrl.halt = 1'b1;  // ecall, ebreak
            default: ctrl.halt = 1'b1;     // unsupported
        endcase
    end

    always_comb begin
        case (opcode)
            OPC_STORE:
                imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            OPC_BRANCH:
                imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:
                imm = {ins[31:12], 12'b0};
            OPC_JAL:
                imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            default:  // i-type
                imm = {{20{ins[31]}}, ins[31:20]};
        endcase
    end

endmodule

//--- rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_isa_pkg::alu_op_e         alu_op,
    input  logic [rv_isa_pkg::xlen-1:0] in_1,
    input  logic [rv_isa_pkg::xlen-1:0] in_2,
    output logic [rv_isa_pkg::xlen-1:0] out,
    output logic                        zero
);
    import rv_isa_pkg::*;

    logic [4:0] shamt;

    assign shamt = in_2[4:0];
    assign zero  = ~|out;  // branch taken flag

    always_comb begin
        case (alu_op)
            ALU_AND:  out = in_1 & in_2;
            ALU_OR:   out = in_1 | in_2;
            ALU_ADD:  out = in_1 + in_2;
            ALU_EQU:  out = {{(xlen-1){1'b0}}, in_1 == in_2};
            ALU_SGE:  out = {{(xlen-1){1'b0}}, $signed(in_1) >= $signed(in_2)};
            ALU_SGEU: out = {{(xlen-1){1'b0}}, in_1 >= in_2};
            ALU_SUB:  out = in_1 - in_2;
            ALU_XOR:  out = in_1 ^ in_2;
            ALU_SLL:  out = in_1 << shamt;
            ALU_SLT:  out = {{(xlen-1){1'b0}}, $signed(in_1) < $signed(in_2)};
            ALU_SLTU: out = {{(xlen-1){1'b0}}, in_1 < in_2};
            ALU_SRL:  out = in_1 >> shamt;
            ALU_SRA:  out = $unsigned($signed(in_1) >>> shamt);  // fills with sign
            ALU_IN1:  out = in_1;
            ALU_IN2:  out = in_2;
            default:  out = in_1 & in_2;
        endcase
    end

endmodule

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 run,
    output logic                 halt,
    output rv_bus_pkg::apb_req_t bus_req,
    input  rv_bus_pkg::apb_rsp_t bus_rsp
);
    import rv_isa_pkg::*;

    typedef enum logic [1:0] {ST_FETCH, ST_EXEC, ST_MEM, ST_HALTED} state_e;

    state_e            state;
    logic [xlen-1:0]   pc;
    logic [xlen-1:0]   pc4;
    logic [xlen-1:0]   ir;
    logic [xlen-1:0]   regs [32];
    ctrl_t             ctrl;
    logic [xlen-1:0]   imm;
    logic [xlen-1:0]   rs1_val, rs2_val;
    logic [xlen-1:0]   alu_in_1, alu_in_2, alu_out;
    logic              zero;
    logic [xlen-1:0]   next_pc;
    logic [xlen-1:0]   lane, ld_data, wb_data;
    logic [31:0]       st_data;
    logic [3:0]        st_strb;
    logic [4:0]        rd;
    logic              bus_done;
    logic              is_mem;
    logic              rf_we;

    rv_decoder u_dec (
        .ins  (ir),
        .ctrl (ctrl),
        .imm  (imm)
    );

    rv_alu u_alu (
        .alu_op (ctrl.alu_op),
        .in_1   (alu_in_1),
        .in_2   (alu_in_2),
        .out    (alu_out),
        .zero   (zero)
    );

    assign rd       = ir[11:7];
    assign rs1_val  = regs[ir[19:15]];  // x0 never written
    assign rs2_val  = regs[ir[24:20]];
    assign pc4      = pc + 32'd4;
    assign alu_in_1 = ctrl.src1_pc ? (ctrl.src1_pc4 ? pc4 : pc) : rs1_val;
    assign alu_in_2 = ctrl.src2_imm ? imm : rs2_val;
    assign bus_done = bus_req.psel & bus_req.penable & bus_rsp.pready;
    assign is_mem   = ctrl.mem_read | ctrl.mem_write;
    assign halt     = (state == ST_HALTED);

    always_comb begin
        if (ctrl.jalr)
            next_pc = {alu_out[xlen-1:1], 1'b0};
        else if (ctrl.jump || (ctrl.branch && zero))
            next_pc = pc + imm;
        else
            next_pc = pc4;
    end

    // load lane select and extension
    always_comb begin
        lane = bus_rsp.prdata >> {alu_out[1:0], 3'b000};
        case (ctrl.mem_size)
            SIZE_BYTE: ld_data = {{24{ctrl.mem_signed & lane[7]}}, lane[7:0]};
            SIZE_HALF: ld_data = {{16{ctrl.mem_signed & lane[15]}}, lane[15:0]};
            default:   ld_data = lane;
        endcase
    end

    // store data replicated over lanes
    always_comb begin
        case (ctrl.mem_size)
            SIZE_BYTE: begin
                st_data = {4{rs2_val[7:0]}};
                st_strb = 4'b0001 << alu_out[1:0];
            end
            SIZE_HALF: begin
                st_data = {2{rs2_val[15:0]}};
                st_strb = alu_out[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_data = rs2_val;
                st_strb = 4'b1111;
            end
        endcase
    end

    assign wb_data = ctrl.mem_to_reg ? ld_data : (ctrl.jalr ? pc4 : alu_out);
    assign rf_we   = ctrl.reg_write &&
                     ((state == ST_EXEC && !is_mem && !ctrl.halt) ||
                      (state == ST_MEM && bus_done && ctrl.mem_read));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we && rd != 5'd0) begin
            regs[rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= ST_FETCH;
            pc              <= '0;
            bus_req.psel    <= 1'b0;
            bus_req.penable <= 1'b0;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (!bus_req.psel) begin
                        if (run) begin  // setup phase for instruction read
                            bus_req.psel   <= 1'b1;
                            bus_req.pwrite <= 1'b0;
                            bus_req.paddr  <= pc;
                            bus_req.pstrb  <= 4'b0000;
                        end
                    end else if (!bus_req.penable) begin
                        bus_req.penable <= 1'b1;
                    end else if (bus_rsp.pready) begin
                        bus_req.psel    <= 1'b0;
                        bus_req.penable <= 1'b0;
                        ir              <= bus_rsp.prdata;
                        state           <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    if (ctrl.halt) begin
                        state <= ST_HALTED;
                    end else if (is_mem) begin
                        bus_req.psel   <= 1'b1;
                        bus_req.pwrite <= ctrl.mem_write;
                        bus_req.paddr  <= {alu_out[xlen-1:2], 2'b00};  // word aligned
                        bus_req.pwdata <= st_data;
                        bus_req.pstrb  <= ctrl.mem_write ? st_strb : 4'b0000;
                        state          <= ST_MEM;
                    end else begin
                        pc    <= next_pc;
                        state <= ST_FETCH;
                    end
                end
                ST_MEM: begin
                    if (!bus_req.penable) begin
                        bus_req.penable <= 1'b1;
                    end else if (bus_rsp.pready) begin
                        bus_req.psel    <= 1'b0;
                        bus_req.penable <= 1'b0;
                        pc              <= pc4;
                        state           <= ST_FETCH;
                    end
                end
                default: state <= ST_HALTED;  // stays until reset
            endcase
        end
    end

endmodule

//--- apb_arbiter.sv
`timescale 1ns/1ps

module apb_arbiter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_bus_pkg::apb_req_t m0_req,
    output rv_bus_pkg::apb_rsp_t m0_rsp,
    input  rv_bus_pkg::apb_req_t m1_req,
    output rv_bus_pkg::apb_rsp_t m1_rsp,
    output rv_bus_pkg::apb_req_t s_req,
    input  rv_bus_pkg::apb_rsp_t s_rsp
);
    import rv_bus_pkg::*;

    apb_req_t own_req;
    logic     busy;
    logic     owner;  // 0 core side, 1 host side
    logic     fresh;  // slave setup cycle
    logic     last;   // previous winner
    logic     pick;
    logic     done;

    assign own_req = owner ? m1_req : m0_req;
    assign pick    = (m0_req.psel && m1_req.psel) ? ~last : m1_req.psel;
    assign done    = s_req.psel & s_req.penable & s_rsp.pready;

    always_comb begin
        s_req = '0;
        if (busy) begin
            s_req         = own_req;
            s_req.penable = own_req.penable & ~fresh;
        end
    end

    assign m0_rsp.pready = busy & ~owner & ~fresh & s_rsp.pready;
    assign m0_rsp.prdata = (busy && !owner) ? s_rsp.prdata : '0;
    assign m1_rsp.pready = busy & owner & ~fresh & s_rsp.pready;
    assign m1_rsp.prdata = (busy && owner) ? s_rsp.prdata : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            owner <= 1'b0;
            fresh <= 1'b0;
            last  <= 1'b1;  // core wins first tie
        end else if (!busy) begin
            if (m0_req.psel || m1_req.psel) begin
                busy  <= 1'b1;
                fresh <= 1'b1;
                owner <= pick;
                last  <= pick;
            end
        end else begin
            fresh <= 1'b0;
            if (done)
                busy <= 1'b0;  // free on completing cycle
        end
    end

endmodule

//--- apb_ram.sv
`timescale 1ns/1ps

module apb_ram (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_bus_pkg::apb_req_t req,
    output rv_bus_pkg::apb_rsp_t rsp
);
    import rv_bus_pkg::*;

    logic [31:0]       mem [mem_words];
    logic [31:0]       rdata;
    logic [mem_aw-1:0] idx;

    assign idx = req.paddr[mem_aw+1:2];  // word index

    // byte lane writes in the access phase
    always_ff @(posedge clk) begin
        if (req.psel && req.penable && req.pwrite) begin
            for (int b = 0; b < 4; b++) begin
                if (req.pstrb[b])
                    mem[idx][8*b +: 8] <= req.pwdata[8*b +: 8];
            end
        end
    end

    // read registered during setup, valid in access
    always_ff @(posedge clk) begin
        if (!rst_n)
            rdata <= '0;
        else if (req.psel && !req.penable)
            rdata <= mem[idx];
    end

    assign rsp.pready = 1'b1;  // no wait states
    assign rsp.prdata = rdata;

endmodule

//--- rv_soc.sv
`timescale 1ns/1ps

module rv_soc (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 run,
    output logic                 halt,
    input  rv_bus_pkg::apb_req_t host_req,
    output rv_bus_pkg::apb_rsp_t host_rsp
);
    import rv_bus_pkg::*;

    apb_req_t core_req, ram_req;
    apb_rsp_t core_rsp, ram_rsp;

    rv_core u_core (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (run),
        .halt    (halt),
        .bus_req (core_req),
        .bus_rsp (core_rsp)
    );

    apb_arbiter u_arb (
        .clk    (clk),
        .rst_n  (rst_n),
        .m0_req (core_req),
        .m0_rsp (core_rsp),
        .m1_req (host_req),
        .m1_rsp (host_rsp),
        .s_req  (ram_req),
        .s_rsp  (ram_rsp)
    );

    apb_ram u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (ram_req),
        .rsp   (ram_rsp)
    );

endmodule

//--- tb_rv_soc.sv
`timescale 1ns/1ps

module tb_rv_soc;
    import rv_bus_pkg::*;

    localparam int cycles_per_line = 200;
    localparam int program_cycles  = 5000;

    logic     clk;
    logic     rst_n;
    logic     run;
    logic     halt;
    apb_req_t host_req;
    apb_rsp_t host_rsp;

    logic [7:0]  cmd_q  [$];  // one entry per data line
    logic [31:0] addr_q [$];
    logic [31:0] data_q [$];
    int          limit_cycles;

    rv_soc u_rv_soc (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),
        .halt     (halt),
        .host_req (host_req),
        .host_rsp (host_rsp)
    );

    always #10 clk = ~clk;  // 20 ns period

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] time %0t %s expected %h actual %h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    // one apb transfer on the host port
    task automatic host_transfer(input logic write, input logic [31:0] addr,
                                 input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        host_req.psel    <= 1'b1;  // setup phase
        host_req.penable <= 1'b0;
        host_req.pwrite  <= write;
        host_req.paddr   <= addr;
        host_req.pwdata  <= wdata;
        host_req.pstrb   <= write ? 4'b1111 : 4'b0000;
        @(posedge clk);
        host_req.penable <= 1'b1;  // access phase held until pready
        @(negedge clk);
        while (!host_rsp.pready) @(negedge clk);
        rdata = host_rsp.prdata;
        @(posedge clk);  // completing edge
        host_req.psel    <= 1'b0;
        host_req.penable <= 1'b0;
    endtask

    task automatic load_testdata();
        int               fd;
        int               n;
        logic [63:0]      tok;
        logic [31:0]      a;
        logic [31:0]      v;
        logic [8*160-1:0] rest;
        fd = $fopen("rv_soc_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open the data file rv_soc_testdata.txt");
            abort_run();
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok[63:8] == '0 && tok[7:0] == "#") begin
                    n = $fgets(rest, fd);  // comment line
                end else begin
                    n = $fscanf(fd, "%h %h", a, v);
                    if (n != 2) begin
                        $display("malformed line in the data file after command %c",
                                 tok[7:0]);
                        abort_run();
                    end else begin
                        cmd_q.push_back(tok[7:0]);
                        addr_q.push_back(a);
                        data_q.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ends the run if the program or a host transfer never finishes
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout waiting for halt or bus response");
        abort_run();
    end

    initial begin
        logic [31:0] rd;
        string       what;
        clk          = 1'b0;
        rst_n       <= 1'b0;
        run         <= 1'b0;
        host_req    <= '0;
        limit_cycles = 0;
        load_testdata();
        limit_cycles = cycles_per_line * cmd_q.size() + program_cycles;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        foreach (cmd_q[i]) begin
            case (cmd_q[i])
                "W": host_transfer(1'b1, addr_q[i], data_q[i], rd);
                "R", "P", "C": begin
                    host_transfer(1'b0, addr_q[i], 32'h0, rd);
                    what = $sformatf("mem[0x%h] on %c read", addr_q[i], cmd_q[i]);
                    compare_word(what, data_q[i], rd);
                    if (cmd_q[i] != "C") begin
                        @(negedge clk);
                        compare_word("halt", 32'h0, {31'b0, halt});  // core still idle or running
                    end
                end
                "G": begin
                    @(posedge clk);
                    run <= 1'b1;
                end
                "H": begin
                    @(negedge clk);
                    while (!halt) @(negedge clk);
                end
                default: begin
                    $display("unknown command %c in the data file", cmd_q[i]);
                    abort_run();
                end
            endcase
        end

        repeat (20) @(negedge clk);
        compare_word("halt after stop", 32'h1, {31'b0, halt});  // stays until reset
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- vlog.f
rv_isa_pkg.sv
rv_bus_pkg.sv
rv_decoder.sv
rv_alu.sv
rv_core.sv
apb_arbiter.sv
apb_ram.sv
rv_soc.sv
tb_rv_soc.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_rv_soc -f vlog.f -o sim_rv_soc \
    && ./obj_dir/sim_rv_soc > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- rv_soc_testdata.txt
# cmd addr value, hex: W host write, R check before run, G start core,
# P check while running, H wait for halt, C check after halt
W 00000000 06400093
W 00000004 ff900113
W 00000008 20000513
W 0000000c 002081b3
W 00000010 00352023
W 00000014 40208233
W 00000018 00452223
W 0000001c 0020c2b3
W 00000020 00552423
W 00000024 0020e333
W 00000028 00652623
W 0000002c 0020f3b3
W 00000030 00752823
W 00000034 00112433
W 00000038 00852a23
W 0000003c 001134b3
W 00000040 00952c23
W 00000044 00409593
W 00000048 00b52e23
W 0000004c 01c15613
W 00000050 02c52023
W 00000054 40115693
W 00000058 02d52223
W 0000005c 12345737
W 00000060 02e52423
W 00000064 00001797
W 00000068 02f52623
W 0000006c 00000813
W 00000070 00500893
W 00000074 00180813
W 00000078 ff181ee3
W 0000007c 00000913
W 00000080 00390913
W 00000084 ff194ee3
W 00000088 03052823
W 0000008c 03252a23
W 00000090 01180463
W 00000094 02052c23
W 00000098 010000ef
W 0000009c 02152e23
W 000000a0 05352023
W 000000a4 0080006f
W 000000a8 000089e7
W 000000ac f8000a93
W 000000b0 095500a3
W 000000b4 00008b37
W 000000b8 09651123
W 000000bc 08150b83
W 000000c0 08154c03
W 000000c4 08251c83
W 000000c8 08255d03
W 000000cc 05752423
W 000000d0 05852623
W 000000d4 05952823
W 000000d8 05a52a23
W 000000dc 00000073
W 000000e0 04152c23
W 00000218 a5a5a5a5
W 00000238 deadbeef
W 00000258 cafef00d
W 00000280 11223344
W 00000300 0badf00d
W 00000304 13579bdf
W 00000308 2468ace0
R 00000000 06400093
R 00000238 deadbeef
R 00000280 11223344
R 00000308 2468ace0
G 00000000 00000000
P 00000300 0badf00d
P 00000304 13579bdf
P 00000308 2468ace0
P 00000300 0badf00d
P 00000304 13579bdf
P 00000308 2468ace0
H 00000000 00000000
C 00000200 0000005d
C 00000204 0000006b
C 00000208 ffffff9d
C 0000020c fffffffd
C 00000210 00000060
C 00000214 00000001
C 00000218 00000000
C 0000021c 00000640
C 00000220 0000000f
C 00000224 fffffffc
C 00000228 12345000
C 0000022c 00001064
C 00000230 00000005
C 00000234 00000006
C 00000238 deadbeef
C 0000023c 0000009c
C 00000240 000000ac
C 00000248 ffffff80
C 0000024c 00000080
C 00000250 ffff8000
C 00000254 00008000
C 00000258 cafef00d
C 00000280 80008044
C 00000300 0badf00d
